// File: design/alu_pkg.sv
// ----------------------------------------------------------------------
// shared types and widths for the register-to-register execution unit
// xlen sets the datapath and the default ALU width
// register index width must cover num_regs
// operation encoding is fixed at 3 bits, 8 functions
// ----------------------------------------------------------------------

package alu_pkg;

    localparam int xlen     = 64; // data width
    localparam int num_regs = 16; // register file depth
    localparam int reg_aw   = 4;  // register index width

    // alu function select, order matches the hardware encoding
    typedef enum logic [2:0] {
        op_sum,         // a + b
        op_sub,         // a - b
        op_shift_left,  // logical a << b
        op_shift_right, // logical a >> b
        op_load,        // pass b
        op_and,         // a & b
        op_xor,         // a ^ b
        op_not          // ~a, b ignored
    } alu_op_e;

    // status flags, compares are signed
    typedef struct packed {
        logic overflow; // signed overflow of sum or difference
        logic negative; // msb of result
        logic zero;     // result is all zero
        logic equal;    // a == b
        logic greater;  // a > b
        logic less;     // a < b
    } alu_flags_t;

    // one command from the requester
    typedef struct packed {
        alu_op_e             op;
        logic [reg_aw-1:0]   rd;      // destination
        logic [reg_aw-1:0]   rs1;     // operand a
        logic [reg_aw-1:0]   rs2;     // operand b unless use_imm
        logic                use_imm; // imm replaces rs2
        logic [xlen-1:0]     imm;
    } exec_cmd_t;

    // response returned with ack
    typedef struct packed {
        logic [xlen-1:0] result;
        alu_flags_t      flags;
    } exec_rsp_t;

endpackage: alu_pkg

// File: design/alu.sv
// ----------------------------------------------------------------------
// 8-function combinational ALU, width set by parameter
// shifts are logical; amount of width or more gives zero
// overflow reports the sum for op_sum, the difference for all else
// equal/greater/less compare a and b as signed numbers
// ----------------------------------------------------------------------

module alu
    import alu_pkg::*;
#(
    parameter int width = xlen
) (
    input  alu_op_e                  op,     // function select
    input  logic signed [width-1:0]  a,      // operand a
    input  logic signed [width-1:0]  b,      // operand b or immediate
    output logic signed [width-1:0]  result,
    output alu_flags_t               flags
);

    logic signed [width-1:0] res_add; // a + b
    logic signed [width-1:0] res_sub; // a - b
    logic signed [width-1:0] res;     // selected result
    logic                    shamt_big; // shift amount out of range
    logic                    ovf_add;
    logic                    ovf_sub;

    assign res_add = a + b;
    assign res_sub = a - b;

    // any amount >= width clears the value
    assign shamt_big = ($unsigned(b) >= width);

    // same-sign inputs, sign flips
    assign ovf_add = (a[width-1] == b[width-1]) && (res_add[width-1] != a[width-1]);
    // opposite-sign inputs, sign of a lost
    assign ovf_sub = (a[width-1] != b[width-1]) && (res_sub[width-1] != a[width-1]);

    always_comb begin
        case (op)
            op_sum:         res = res_add;
            op_sub:         res = res_sub;
            op_shift_left:  res = shamt_big ? '0 : (a << $unsigned(b));
            op_shift_right: res = shamt_big ? '0 : (a >> $unsigned(b)); // zero fill
            op_load:        res = b;                 // pass-through
            op_and:         res = a & b;
            op_xor:         res = a ^ b;
            op_not:         res = ~a;                // b unused here
            default:        res = '0;
        endcase
    end

    assign result = res;

    // flags
    assign flags.overflow = (op == op_sum) ? ovf_add : ovf_sub;
    assign flags.negative = res[width-1];
    assign flags.zero     = (res == '0);
    assign flags.equal    = (a == b);
    assign flags.greater  = (a > b);  // signed, both operands signed
    assign flags.less     = (a < b);

    // a known operand pair with an unknown op means the flags
    // downstream would be garbage
    always_comb begin
        a_op_known: assert final ($isunknown({a, b}) || !$isunknown(op))
            else $error("alu op is unknown while operands are valid");
    end

endmodule: alu

// File: design/reg_file.sv
// ----------------------------------------------------------------------
// register file, num_regs x xlen, all entries cleared on reset
// two combinational read ports, one write port on the clock edge
// read of the entry being written returns the old value
// ----------------------------------------------------------------------

module reg_file
    import alu_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic [reg_aw-1:0] raddr_a, // operand a index
    input  logic [reg_aw-1:0] raddr_b, // operand b index
    output logic [xlen-1:0]   rdata_a,
    output logic [xlen-1:0]   rdata_b,
    input  logic              we,      // write strobe
    input  logic [reg_aw-1:0] waddr,
    input  logic [xlen-1:0]   wdata
);

    logic [xlen-1:0] regs [num_regs]; // storage

    // single write port
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0; // all zero after reset
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // no bypass, new value shows after the edge
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    // write address must be clean when strobed
    a_waddr_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        we |-> !$isunknown(waddr)
    ) else $error("reg_file write with unknown waddr");

endmodule: reg_file

// File: design/exec_ctrl.sv
// ----------------------------------------------------------------------
// control FSM for the execution unit
// four-phase req/ack; one command in flight at a time
// edge 1 captures cmd, edge 2 writes rd, loads rsp, raises ack
// ack and rsp hold until req is sampled low
// cmd must stay stable while req is high
// ----------------------------------------------------------------------

module exec_ctrl
    import alu_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req,        // from requester
    input  exec_cmd_t         cmd,
    output logic              ack,        // registered
    output exec_rsp_t         rsp,        // registered, valid with ack
    output logic [reg_aw-1:0] raddr_a,    // rs1
    output logic [reg_aw-1:0] raddr_b,    // rs2
    input  logic [xlen-1:0]   rdata_b,
    output alu_op_e           alu_op,
    output logic [xlen-1:0]   alu_b,      // imm or rdata_b
    input  logic [xlen-1:0]   alu_result,
    input  alu_flags_t        alu_flags,
    output logic              we,
    output logic [reg_aw-1:0] waddr,
    output logic [xlen-1:0]   wdata
);

    typedef enum logic [1:0] {
        st_idle, // waiting for req
        st_exec, // operands valid, write back this cycle
        st_hold  // ack high, waiting for req low
    } state_e;

    state_e    state_q;
    state_e    state_d;
    exec_cmd_t cmd_q;   // captured command

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: if (req) state_d = st_exec;
            st_exec: state_d = st_hold;      // always one cycle
            st_hold: if (!req) state_d = st_idle;
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
            cmd_q   <= '0;   // keeps alu_op known out of reset
            ack     <= 1'b0;
            rsp     <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == st_idle && req) begin
                cmd_q <= cmd; // E1
            end
            if (state_q == st_exec) begin
                ack        <= 1'b1; // E2
                rsp.result <= alu_result;
                rsp.flags  <= alu_flags;
            end else if (state_q == st_hold && !req) begin
                ack <= 1'b0; // release
            end
        end
    end

    // datapath steering from the captured command
    assign raddr_a = cmd_q.rs1;
    assign raddr_b = cmd_q.rs2;
    assign alu_op  = cmd_q.op;
    assign alu_b   = cmd_q.use_imm ? cmd_q.imm : rdata_b;

    // write-back in the exec cycle only
    assign we    = (state_q == st_exec);
    assign waddr = cmd_q.rd;
    assign wdata = alu_result;

    // ack rises only for a request seen on the previous edge
    a_ack_after_req: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(ack) |-> $past(req)
    ) else $error("ack rose without req");

    // back-pressure: response frozen while ack stays high
    a_rsp_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        ack && $past(ack) |-> $stable(rsp)
    ) else $error("rsp changed while ack high");

    // one write per command, followed by the ack rise
    a_one_write: assert property (
        @(posedge clk) disable iff (!arst_n)
        we |=> !we && $rose(ack)
    ) else $error("write strobe longer than one cycle or not followed by ack");

endmodule: exec_ctrl

// File: design/exec_unit.sv
// ----------------------------------------------------------------------
// top of the register-to-register execution unit
// one command per four-phase req/ack transaction
// ack appears after the second edge that sees req high
// ----------------------------------------------------------------------

module exec_unit
    import alu_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      req,  // command request
    input  exec_cmd_t cmd,  // stable while req high
    output logic      ack,
    output exec_rsp_t rsp   // valid while ack high
);

    logic [reg_aw-1:0] raddr_a;
    logic [reg_aw-1:0] raddr_b;
    logic [xlen-1:0]   rdata_a;    // straight to alu operand a
    logic [xlen-1:0]   rdata_b;    // muxed with imm in ctrl
    alu_op_e           alu_op;
    logic [xlen-1:0]   alu_b;
    logic [xlen-1:0]   alu_result;
    alu_flags_t        alu_flags;
    logic              we;
    logic [reg_aw-1:0] waddr;
    logic [xlen-1:0]   wdata;

    exec_ctrl ctrl_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .cmd        (cmd),
        .ack        (ack),
        .rsp        (rsp),
        .raddr_a    (raddr_a),
        .raddr_b    (raddr_b),
        .rdata_b    (rdata_b),
        .alu_op     (alu_op),
        .alu_b      (alu_b),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .we         (we),
        .waddr      (waddr),
        .wdata      (wdata)
    );

    reg_file rf_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .we      (we),
        .waddr   (waddr),
        .wdata   (wdata)
    );

    alu #(
        .width (xlen)
    ) alu_i (
        .op     (alu_op),
        .a      (rdata_a),
        .b      (alu_b),
        .result (alu_result),
        .flags  (alu_flags)
    );

endmodule: exec_unit

// File: testbench/exec_unit_tb.sv
// ----------------------------------------------------------------------
// testbench for exec_unit, one four-phase transaction per command
// inputs change 10 ns after the rising edge, checks sample at the edge
// expected responses come from a register mirror and a reference model
// concurrent assertions check response values and req/ack protocol
// watchdog bounds the run at reset time plus 300 slow commands
// ----------------------------------------------------------------------

module exec_unit_tb
    import alu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int     clk_period   = 100;
    localparam int     drive_dly    = 10;  // after rising edge
    localparam int     reset_cycles = 8;
    localparam int     ack_wait_max = 20;  // cycles per handshake phase
    localparam longint watchdog_ns  = reset_cycles * clk_period + 300 * 20 * clk_period;

    logic      clk;
    logic      arst_n;
    logic      req;
    exec_cmd_t cmd;
    logic      ack;
    exec_rsp_t rsp;

    logic [31:0]     lcg_state = 32'h6cb5;
    logic [xlen-1:0] mirror_regs [num_regs]; // model of the register file
    exec_rsp_t       exp_rsp;                // response of the command in flight
    int              err_count    = 0;
    int              cmd_count    = 0;
    int              test_num     = 0;
    int              tests_passed = 0;
    int              tests_failed = 0;
    int              err_mark     = 0;
    int              cmd_mark     = 0;

    exec_unit dut_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .cmd    (cmd),
        .ack    (ack),
        .rsp    (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ack and rsp clear straight out of reset
    reset_clear: assert property (@(posedge clk) $rose(arst_n) |-> !ack && rsp == '0)
    else begin
        $display("[ERROR] t=%0t ack expected 0 got %b, rsp expected 0 got %h",
                 $time, $sampled(ack), $sampled(rsp));
        err_count++;
    end

    // E1 then E2, ack seen high at the edge after that
    ack_rise_time: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(req) |-> ##2 $rose(ack)
    ) else begin
        $display("ack did not rise at the second edge after req was seen high (t=%0t)", $time);
        err_count++;
    end

    ack_needs_req: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(ack) |-> $past(req, 1) && $past(req, 2)
    ) else begin
        $display("ack rose without req held high for two edges (t=%0t)", $time);
        err_count++;
    end

    ack_fall_after_req: assert property (
        @(posedge clk) disable iff (!arst_n) $fell(ack) |-> !$past(req)
    ) else begin
        $display("ack fell while req was still high (t=%0t)", $time);
        err_count++;
    end

    // release at the first edge that sees req low
    ack_release: assert property (
        @(posedge clk) disable iff (!arst_n) ack && !req |=> !ack
    ) else begin
        $display("ack did not fall at the first edge that saw req low (t=%0t)", $time);
        err_count++;
    end

    // back-pressure hold
    ack_hold: assert property (
        @(posedge clk) disable iff (!arst_n) ack && req |=> ack && $stable(rsp)
    ) else begin
        $display("ack dropped or rsp changed while req was still held (t=%0t)", $time);
        err_count++;
    end

    // requester side rule, guards the stimulus itself
    req_while_ack_low: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(req) |-> !ack
    ) else begin
        $display("req rose while ack was still high (t=%0t)", $time);
        err_count++;
    end

    result_check: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(ack) |-> rsp.result == exp_rsp.result
    ) else begin
        $display("[ERROR] t=%0t rsp.result expected %h got %h",
                 $time, exp_rsp.result, $sampled(rsp.result));
        err_count++;
    end

    flags_check: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(ack) |-> rsp.flags == exp_rsp.flags
    ) else begin
        $display("[ERROR] t=%0t rsp.flags (ovf,neg,zero,eq,gt,lt) expected %b got %b",
                 $time, exp_rsp.flags, $sampled(rsp.flags));
        err_count++;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [xlen-1:0] rand64();
        return {lcg_next(), lcg_next()};
    endfunction

    function automatic logic [reg_aw-1:0] rand_reg();
        logic [31:0] r;
        r = lcg_next();
        return r[27:24]; // upper bits, low ones cycle fast
    endfunction

    // reference model, from the operation rules
    function automatic exec_rsp_t expected_rsp(input alu_op_e op,
                                               input logic [xlen-1:0] a,
                                               input logic [xlen-1:0] b);
        exec_rsp_t   r;
        logic [xlen:0] sum_x; // one extra sign bit
        logic [xlen:0] dif_x;
        sum_x = {a[xlen-1], a} + {b[xlen-1], b};
        dif_x = {a[xlen-1], a} - {b[xlen-1], b};
        case (op)
            op_sum:         r.result = sum_x[xlen-1:0];
            op_sub:         r.result = dif_x[xlen-1:0];
            op_shift_left:  r.result = (b >= xlen) ? '0 : a << b;
            op_shift_right: r.result = (b >= xlen) ? '0 : a >> b;
            op_load:        r.result = b;
            op_and:         r.result = a & b;
            op_xor:         r.result = a ^ b;
            default:        r.result = ~a; // op_not
        endcase
        // extended sign disagrees with the truncated one on overflow
        r.flags.overflow = (op == op_sum) ? (sum_x[xlen] ^ sum_x[xlen-1])
                                          : (dif_x[xlen] ^ dif_x[xlen-1]);
        r.flags.negative = r.result[xlen-1];
        r.flags.zero     = (r.result == '0);
        r.flags.equal    = (a == b);
        r.flags.greater  = ($signed(a) > $signed(b));
        r.flags.less     = ($signed(a) < $signed(b));
        return r;
    endfunction

    function automatic exec_cmd_t make_cmd(input alu_op_e op, input logic [reg_aw-1:0] rd,
                                           input logic [reg_aw-1:0] rs1,
                                           input logic [reg_aw-1:0] rs2,
                                           input logic use_imm, input logic [xlen-1:0] imm);
        exec_cmd_t c;
        c.op      = op;
        c.rd      = rd;
        c.rs1     = rs1;
        c.rs2     = rs2;
        c.use_imm = use_imm;
        c.imm     = imm;
        return c;
    endfunction

    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        while (ack !== level && cycles < ack_wait_max) begin
            @(posedge clk);
            #drive_dly;
            cycles++;
        end
        if (ack !== level) begin
            $display("timeout: ack did not go to %b within %0d cycles (t=%0t)",
                     level, ack_wait_max, $time);
            err_count++;
        end
    endtask

    // one full four-phase transaction, hold = extra cycles of req after ack
    task automatic run_cmd(input exec_cmd_t c, input int hold);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        a = mirror_regs[c.rs1];
        b = c.use_imm ? c.imm : mirror_regs[c.rs2];
        exp_rsp = expected_rsp(c.op, a, b);
        mirror_regs[c.rd] = exp_rsp.result; // model writes at issue
        cmd = c;
        req = 1'b1;
        wait_ack(1'b1);
        repeat (hold) begin
            @(posedge clk);
            #drive_dly;
        end
        req = 1'b0;
        wait_ack(1'b0);
        cmd_count++;
    endtask

    task automatic load_reg(input logic [reg_aw-1:0] rd, input logic [xlen-1:0] value);
        run_cmd(make_cmd(op_load, rd, rand_reg(), rand_reg(), 1'b1, value), 0);
    endtask

    task automatic read_back(input logic [reg_aw-1:0] idx);
        run_cmd(make_cmd(op_sum, idx, idx, rand_reg(), 1'b1, '0), 0); // rd = rs1 + 0
    endtask

    task automatic random_cmd(input alu_op_e op, input logic allow_imm);
        logic [31:0] r;
        r = lcg_next();
        run_cmd(make_cmd(op, rand_reg(), rand_reg(), rand_reg(), allow_imm & r[20],
                         rand64()), 0);
    endtask

    task automatic finish_test(input string name);
        int errs;
        test_num++;
        errs = err_count - err_mark;
        $display("test %0d %s: %0d commands, %0d errors%s", test_num, name,
                 cmd_count - cmd_mark, errs, (errs == 0) ? ", ok" : "");
        if (errs == 0) tests_passed++;
        else tests_failed++;
        err_mark = err_count;
        cmd_mark = cmd_count;
    endtask

    task automatic test_shifts();
        logic [xlen-1:0] amt [7];
        amt = '{64'd0, 64'd1, 64'd63, 64'd64, 64'd65, rand64() | 64'h40, {lcg_next(), 32'h7}};
        load_reg(4'd7, rand64());
        load_reg(4'd8, rand64() | 64'h8000_0000_0000_0000); // msb set, shows zero fill
        foreach (amt[i]) begin
            run_cmd(make_cmd(op_shift_left, 4'd9, 4'd7, 4'd0, 1'b1, amt[i]), 0);
            run_cmd(make_cmd(op_shift_right, 4'd10, 4'd8, 4'd0, 1'b1, amt[i]), 0);
        end
        // amount from a register
        load_reg(4'd11, 64'd5);
        load_reg(4'd12, 64'd200);
        run_cmd(make_cmd(op_shift_left, 4'd13, 4'd7, 4'd11, 1'b0, '0), 0);
        run_cmd(make_cmd(op_shift_right, 4'd14, 4'd8, 4'd11, 1'b0, '0), 0);
        run_cmd(make_cmd(op_shift_right, 4'd15, 4'd8, 4'd12, 1'b0, '0), 0);
    endtask

    initial begin
        arst_n = 1'b0;
        req    = 1'b0;
        cmd    = '0;
        exp_rsp = '0;
        foreach (mirror_regs[i]) mirror_regs[i] = '0;
        repeat (reset_cycles) @(posedge clk);
        #drive_dly;
        arst_n = 1'b1;

        // 1: reset values and handshake timing
        load_reg(4'd0, 64'h0123_4567_89ab_cdef);
        read_back(4'd0);
        finish_test("reset and protocol");

        // 2: fill every register, then read each one back
        for (int i = 0; i < num_regs; i++) load_reg(i[reg_aw-1:0], rand64());
        for (int i = 0; i < num_regs; i++) read_back(i[reg_aw-1:0]);
        finish_test("load and read-back");

        // 3: random sum/sub between registers, then directed corners
        for (int i = 0; i < 60; i++) begin
            if (lcg_next() > 32'h8000_0000) random_cmd(op_sum, 1'b0);
            else random_cmd(op_sub, 1'b0);
        end
        load_reg(4'd1, 64'h7fff_ffff_ffff_ffff); // max positive
        load_reg(4'd2, 64'd1);
        load_reg(4'd4, 64'h8000_0000_0000_0000); // min negative
        run_cmd(make_cmd(op_sum, 4'd3, 4'd1, 4'd2, 1'b0, '0), 0); // positive overflow
        run_cmd(make_cmd(op_sub, 4'd5, 4'd4, 4'd2, 1'b0, '0), 0); // negative overflow
        run_cmd(make_cmd(op_sum, 4'd6, 4'd4, 4'd4, 1'b0, '0), 0); // wraps to zero
        run_cmd(make_cmd(op_sub, 4'd7, 4'd1, 4'd1, 1'b0, '0), 0); // equal operands
        run_cmd(make_cmd(op_sum, 4'd8, 4'd2, 4'd0, 1'b1, '1), 0); // 1 + -1
        run_cmd(make_cmd(op_sub, 4'd9, 4'd1, 4'd4, 1'b0, '0), 0); // max - min
        finish_test("arithmetic and flags");

        test_shifts();
        finish_test("shifts");

        // 5: logic ops, op_not gets random rs2 or imm
        for (int i = 0; i < 10; i++) random_cmd(op_and, 1'b1);
        for (int i = 0; i < 10; i++) random_cmd(op_xor, 1'b1);
        for (int i = 0; i < 10; i++) random_cmd(op_not, 1'b1);
        finish_test("logic operations");

        // 6: rd = rs1 accumulate, a double write would add imm twice
        for (int i = 0; i < 12; i++) begin
            logic [reg_aw-1:0] r;
            int                hold;
            r    = rand_reg();
            hold = 1 + int'((lcg_next() >> 16) % 7);
            run_cmd(make_cmd(op_sum, r, r, rand_reg(), 1'b1, rand64()), hold);
        end
        for (int i = 0; i < num_regs; i++) read_back(i[reg_aw-1:0]);
        finish_test("back-pressure");

        repeat (3) @(posedge clk); // let the last checks settle
        $display("summary: %0d tests passed, %0d tests failed, %0d commands, %0d errors",
                 tests_passed, tests_failed, cmd_count, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // hang guard
    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the run did not complete", watchdog_ns);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule: exec_unit_tb

// File: verilog.f
design/alu_pkg.sv
design/alu.sv
design/reg_file.sv
design/exec_ctrl.sv
design/exec_unit.sv
testbench/exec_unit_tb.sv

// File: Bender.yml
package:
  name: exec_unit

sources:
  - files:
      - design/alu_pkg.sv
      - design/alu.sv
      - design/reg_file.sv
      - design/exec_ctrl.sv
      - design/exec_unit.sv
  - target: test
    files:
      - testbench/exec_unit_tb.sv
